// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_bpu_top
FILELIST  ?= bpu_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard tb/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bpu_top.f
+incdir+tb
source/bpu_pkg.sv
source/bpu_update_if.sv
source/ubtb.sv
source/pht.sv
source/pred_combine.sv
source/bpu_top.sv
tb/tb_bpu_top.sv

// File: source/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    localparam int vaddr_w     = 32;
    localparam int block_bytes = 32;                    // Fetch block size in bytes

    localparam int ubtb_size   = 8;
    localparam int ubtb_idx_w  = $clog2(ubtb_size);
    localparam int ubtb_tag_w  = 14;                    // pc[15:2]

    localparam int pht_idx_w   = 6;                     // pc[7:2]
    localparam int pht_size    = 1 << pht_idx_w;

    localparam logic [1:0] ctr_init = 2'b01;            // Weakly not taken
    localparam logic [1:0] ctr_max  = 2'b11;
    localparam logic [1:0] ctr_min  = 2'b00;

    typedef enum logic [0:0] {
        br_cond = 1'b0,
        br_jump = 1'b1
    } br_type_e;

    // One micro BTB entry, 48 bits
    typedef struct packed {
        logic                  valid;
        logic [ubtb_tag_w-1:0] tag;
        logic [vaddr_w-1:0]    target;
        br_type_e              br_type;
    } ubtb_entry_t;

    // Registered lookup answer, 66 bits
    typedef struct packed {
        logic               hit;
        br_type_e           br_type;
        logic [vaddr_w-1:0] target;
        logic [vaddr_w-1:0] fallthrough;
    } ubtb_resp_t;

endpackage

`default_nettype wire

// File: source/bpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_top (
    input  logic                        clk,
    input  logic                        rst_n,
    // Lookup request
    input  logic                        req_valid,
    input  logic [bpu_pkg::vaddr_w-1:0] req_pc,
    // Training
    input  logic                        upd_valid,
    input  logic [bpu_pkg::vaddr_w-1:0] upd_pc,
    input  logic [bpu_pkg::vaddr_w-1:0] upd_target,
    input  bpu_pkg::br_type_e           upd_type,
    input  logic                        upd_taken,
    // Prediction, one cycle after the request
    output logic                        pred_valid,
    output logic                        pred_hit,
    output logic                        pred_taken,
    output bpu_pkg::br_type_e           pred_type,
    output logic [bpu_pkg::vaddr_w-1:0] pred_target
);

    bpu_update_if        upd_if ();
    bpu_pkg::ubtb_resp_t ubtb_resp;
    logic                resp_valid;
    logic                pred_dir;

    assign upd_if.valid   = upd_valid;
    assign upd_if.pc      = upd_pc;
    assign upd_if.target  = upd_target;
    assign upd_if.br_type = upd_type;
    assign upd_if.taken   = upd_taken;

    ubtb u_ubtb (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_pc     (req_pc),
        .upd        (upd_if.sink),
        .resp_valid (resp_valid),
        .resp       (ubtb_resp)
    );

    pht u_pht (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_pc   (req_pc),
        .upd      (upd_if.sink),
        .pred_dir (pred_dir)
    );

    pred_combine u_combine (
        .resp_valid  (resp_valid),
        .resp        (ubtb_resp),
        .pred_dir    (pred_dir),
        .pred_valid  (pred_valid),
        .pred_hit    (pred_hit),
        .pred_taken  (pred_taken),
        .pred_type   (pred_type),
        .pred_target (pred_target)
    );

endmodule

`default_nettype wire

// File: source/bpu_update_if.sv
`timescale 1ns/1ps
`default_nettype none

// Training update shared by the micro BTB and the counter table
interface bpu_update_if;

    logic                        valid;
    logic [bpu_pkg::vaddr_w-1:0] pc;
    logic [bpu_pkg::vaddr_w-1:0] target;
    bpu_pkg::br_type_e           br_type;
    logic                        taken;

    modport source (
        output valid, pc, target, br_type, taken
    );

    modport sink (
        input valid, pc, target, br_type, taken
    );

endinterface

`default_nettype wire

// File: source/pht.sv
`timescale 1ns/1ps
`default_nettype none

module pht (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [bpu_pkg::vaddr_w-1:0] req_pc,
    bpu_update_if.sink                  upd,
    output logic                        pred_dir
);

    logic [1:0]                    ctrs [bpu_pkg::pht_size];
    logic [bpu_pkg::pht_idx_w-1:0] req_idx;
    logic [bpu_pkg::pht_idx_w-1:0] upd_idx;
    logic [1:0]                    upd_ctr;
    logic [1:0]                    next_ctr;
    logic                          train;

    assign req_idx = req_pc[bpu_pkg::pht_idx_w+1:2];
    assign upd_idx = upd.pc[bpu_pkg::pht_idx_w+1:2];
    assign upd_ctr = ctrs[upd_idx];
    assign train   = upd.valid && (upd.br_type == bpu_pkg::br_cond);   // Jumps leave counters

    // Saturating step
    always_comb begin
        next_ctr = upd_ctr;
        if (upd.taken) begin
            if (upd_ctr != bpu_pkg::ctr_max) begin
                next_ctr = upd_ctr + 2'd1;
            end
        end else if (upd_ctr != bpu_pkg::ctr_min) begin
            next_ctr = upd_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < bpu_pkg::pht_size; i++) begin
                ctrs[i] <= bpu_pkg::ctr_init;
            end
        end else if (train) begin
            ctrs[upd_idx] <= next_ctr;
        end
    end

    always_ff @(posedge clk) begin
        pred_dir <= ctrs[req_idx][1];   // Old value on same-edge update
    end

endmodule

`default_nettype wire

// File: source/pred_combine.sv
`timescale 1ns/1ps
`default_nettype none

module pred_combine (
    input  logic                        resp_valid,
    input  bpu_pkg::ubtb_resp_t         resp,
    input  logic                        pred_dir,
    output logic                        pred_valid,
    output logic                        pred_hit,
    output logic                        pred_taken,
    output bpu_pkg::br_type_e           pred_type,
    output logic [bpu_pkg::vaddr_w-1:0] pred_target
);

    logic taken;

    always_comb begin
        if (!resp.hit) begin
            taken = 1'b0;
        end else if (resp.br_type == bpu_pkg::br_jump) begin
            taken = 1'b1;                   // Jumps ignore the counter
        end else begin
            taken = pred_dir;
        end
    end

    assign pred_valid  = resp_valid;
    assign pred_hit    = resp.hit;
    assign pred_taken  = taken;
    assign pred_type   = resp.hit ? resp.br_type : bpu_pkg::br_cond;
    assign pred_target = taken ? resp.target : resp.fallthrough;

endmodule

`default_nettype wire

// File: source/ubtb.sv
`timescale 1ns/1ps
`default_nettype none

module ubtb (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,
    input  logic [bpu_pkg::vaddr_w-1:0] req_pc,
    bpu_update_if.sink                  upd,
    output logic                        resp_valid,
    output bpu_pkg::ubtb_resp_t         resp
);

    bpu_pkg::ubtb_entry_t           entries [bpu_pkg::ubtb_size];
    logic [bpu_pkg::ubtb_size-1:0]  valid_vec;
    logic [bpu_pkg::ubtb_size-1:0]  lookup_hits;
    logic [bpu_pkg::ubtb_size-1:0]  upd_hits;
    logic [bpu_pkg::ubtb_tag_w-1:0] lookup_tag;
    logic [bpu_pkg::ubtb_tag_w-1:0] upd_tag;
    logic [bpu_pkg::ubtb_idx_w-1:0] lookup_idx;
    logic [bpu_pkg::ubtb_idx_w-1:0] upd_idx;
    logic [bpu_pkg::ubtb_idx_w-1:0] rr_ptr;
    logic                           upd_hit;
    logic                           has_free;

    // Lowest set bit of a way vector
    function automatic logic [bpu_pkg::ubtb_idx_w-1:0] first_set(
        input logic [bpu_pkg::ubtb_size-1:0] vec
    );
        logic [bpu_pkg::ubtb_idx_w-1:0] idx;
        idx = '0;
        for (int i = bpu_pkg::ubtb_size - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = bpu_pkg::ubtb_idx_w'(i);
            end
        end
        return idx;
    endfunction

    assign lookup_tag = req_pc[bpu_pkg::ubtb_tag_w+1:2];
    assign upd_tag    = upd.pc[bpu_pkg::ubtb_tag_w+1:2];

    for (genvar i = 0; i < bpu_pkg::ubtb_size; i++) begin : g_cmp
        assign valid_vec[i]   = entries[i].valid;
        assign lookup_hits[i] = entries[i].valid && (entries[i].tag == lookup_tag);
        assign upd_hits[i]    = entries[i].valid && (entries[i].tag == upd_tag);
    end

    assign upd_hit    = |upd_hits;
    assign has_free   = ~&valid_vec;
    assign lookup_idx = first_set(lookup_hits);

    // Match in place, else first free way, else round-robin victim
    always_comb begin
        if (upd_hit) begin
            upd_idx = first_set(upd_hits);
        end else if (has_free) begin
            upd_idx = first_set(~valid_vec);
        end else begin
            upd_idx = rr_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < bpu_pkg::ubtb_size; i++) begin
                entries[i].valid <= 1'b0;
            end
            rr_ptr <= '0;
        end else if (upd.valid) begin
            entries[upd_idx] <= '{valid:   1'b1,
                                  tag:     upd_tag,
                                  target:  upd.target,
                                  br_type: upd.br_type};
            if (!upd_hit && !has_free) begin
                rr_ptr <= (rr_ptr == bpu_pkg::ubtb_idx_w'(bpu_pkg::ubtb_size - 1)) ?
                          '0 : rr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            resp.hit         <= |lookup_hits;
            resp.br_type     <= entries[lookup_idx].br_type;
            resp.target      <= entries[lookup_idx].target;
            resp.fallthrough <= req_pc + bpu_pkg::vaddr_w'(bpu_pkg::block_bytes);
        end
    end

    // Tags stay unique only if updates always rewrite a matching way
    a_lookup_onehot : assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(lookup_hits)
    ) else $error("ubtb: multiple lookup hits");

    a_upd_onehot : assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(upd_hits)
    ) else $error("ubtb: multiple update hits");

endmodule

`default_nettype wire

// File: tb/bpu_model.svh
`ifndef BPU_MODEL_SVH
`define BPU_MODEL_SVH
`default_nettype none

// Mirror of the micro BTB, its victim pointer and the counter table
logic        m_valid  [bpu_pkg::ubtb_size];
logic [13:0] m_tag    [bpu_pkg::ubtb_size];
logic [31:0] m_target [bpu_pkg::ubtb_size];
logic        m_jump   [bpu_pkg::ubtb_size];
logic [1:0]  m_ctr    [bpu_pkg::pht_size];
int          m_ptr;

task automatic model_reset();
    for (int i = 0; i < bpu_pkg::ubtb_size; i++) begin
        m_valid[i] = 1'b0;
    end
    for (int i = 0; i < bpu_pkg::pht_size; i++) begin
        m_ctr[i] = 2'b01;                               // Weakly not taken
    end
    m_ptr = 0;
endtask

// Combine rule applied to the current table state
task automatic model_predict(input logic [31:0] pc, output logic hit, output logic taken,
                             output logic jump, output logic [31:0] target);
    int way;
    hit = 1'b0;
    way = 0;
    for (int i = 0; i < bpu_pkg::ubtb_size; i++) begin
        if (m_valid[i] && m_tag[i] == pc[15:2]) begin
            hit = 1'b1;
            way = i;
        end
    end
    jump = hit && m_jump[way];
    if (!hit) begin
        taken = 1'b0;
    end else if (jump) begin
        taken = 1'b1;
    end else begin
        taken = m_ctr[pc[7:2]][1];
    end
    target = taken ? m_target[way] : pc + 32'd32;
endtask

task automatic model_train(input logic [31:0] pc, input logic [31:0] target,
                           input logic jump, input logic taken);
    int way;
    way = -1;
    for (int i = 0; i < bpu_pkg::ubtb_size; i++) begin
        if (m_valid[i] && m_tag[i] == pc[15:2]) begin
            way = i;
        end
    end
    if (way < 0) begin
        for (int i = 0; i < bpu_pkg::ubtb_size; i++) begin
            if (!m_valid[i] && way < 0) begin
                way = i;                                // Lowest free way
            end
        end
    end
    if (way < 0) begin
        way   = m_ptr;
        m_ptr = (m_ptr + 1) % bpu_pkg::ubtb_size;
    end
    m_valid[way]  = 1'b1;
    m_tag[way]    = pc[15:2];
    m_target[way] = target;
    m_jump[way]   = jump;
    if (!jump) begin
        if (taken && m_ctr[pc[7:2]] != 2'b11) begin
            m_ctr[pc[7:2]] = m_ctr[pc[7:2]] + 2'b01;
        end else if (!taken && m_ctr[pc[7:2]] != 2'b00) begin
            m_ctr[pc[7:2]] = m_ctr[pc[7:2]] - 2'b01;
        end
    end
endtask

`default_nettype wire
`endif

// File: tb/tb_bpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bpu_top;

    logic                        clk;
    logic                        rst_n;
    logic                        req_valid;
    logic [bpu_pkg::vaddr_w-1:0] req_pc;
    logic                        upd_valid;
    logic [bpu_pkg::vaddr_w-1:0] upd_pc;
    logic [bpu_pkg::vaddr_w-1:0] upd_target;
    bpu_pkg::br_type_e           upd_type;
    logic                        upd_taken;
    logic                        pred_valid;
    logic                        pred_hit;
    logic                        pred_taken;
    bpu_pkg::br_type_e           pred_type;
    logic [bpu_pkg::vaddr_w-1:0] pred_target;

    typedef struct {
        logic        valid;
        logic        hit;
        logic        taken;
        logic        jump;
        logic [31:0] target;
    } expect_t;

    integer  seed;
    expect_t pend;                                      // Lookup driven this edge
    expect_t due;                                       // Lookup answered this cycle

    `include "bpu_model.svh"

    bpu_top u_dut (.*);

    always #2 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Twelve pcs with distinct tags and distinct counter indices
    function automatic logic [31:0] pool_pc(input int idx);
        return 32'h8000_0000 + 32'(idx) * 32'h44;
    endfunction

    task automatic run_cycle(input logic rv, input int rp, input logic uv, input int up,
                             input logic [31:0] ut, input bpu_pkg::br_type_e ty,
                             input logic tk);
        @(posedge clk);
        req_valid  <= rv;
        req_pc     <= pool_pc(rp);
        upd_valid  <= uv;
        upd_pc     <= pool_pc(up);
        upd_target <= ut;
        upd_type   <= ty;
        upd_taken  <= tk;
        due        = pend;
        pend.valid = rv;
        model_predict(pool_pc(rp), pend.hit, pend.taken, pend.jump, pend.target);
        if (uv) begin
            model_train(pool_pc(up), ut, ty == bpu_pkg::br_jump, tk);   // After the lookup
        end
        @(negedge clk);
        check("pred_valid", 32'(pred_valid), 32'(due.valid));
        if (due.valid) begin
            check("pred_hit", 32'(pred_hit), 32'(due.hit));
            check("pred_taken", 32'(pred_taken), 32'(due.taken));
            check("pred_type", 32'(pred_type), 32'(due.jump));
            check("pred_target", pred_target, due.target);
        end
    endtask

    task automatic lookup_pc(input int idx);
        run_cycle(1'b1, idx, 1'b0, 0, 32'h0, bpu_pkg::br_cond, 1'b0);
    endtask

    task automatic train_pc(input int idx, input logic [31:0] tgt, input bpu_pkg::br_type_e ty,
                            input logic tk);
        run_cycle(1'b0, 0, 1'b1, idx, tgt, ty, tk);
    endtask

    // First lookup after reset answers exactly one cycle later
    task automatic latency_test();
        int cycles;
        cycles = 0;
        @(posedge clk);
        req_valid <= 1'b1;
        req_pc    <= pool_pc(0);
        @(posedge clk);
        req_valid <= 1'b0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 10) begin
                abort_run("Timeout: pred_valid never rose after the first lookup");
            end
        end while (!pred_valid);
        check("latency", 32'(cycles), 32'd1);
        check("pred_hit", 32'(pred_hit), 32'd0);
        check("pred_target", pred_target, pool_pc(0) + 32'd32);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] tgt;
        seed       = 32'h51f4c3a8;
        clk        = 1'b0;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_pc     = '0;
        upd_valid  = 1'b0;
        upd_pc     = '0;
        upd_target = '0;
        upd_type   = bpu_pkg::br_cond;
        upd_taken  = 1'b0;
        pend.valid = 1'b0;
        model_reset();
        repeat (7) begin
            @(posedge clk);
            req_valid <= 1'b1;                          // Dropped while in reset
            @(negedge clk);
            check("pred_valid", 32'(pred_valid), 32'd0);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        rst_n     <= 1'b1;
        latency_test();
        for (int i = 0; i < 12; i++) begin
            lookup_pc(i);                               // Cold misses
        end
        run_cycle(1'b1, 1, 1'b1, 1, 32'h0000_4000, bpu_pkg::br_jump, 1'b1);
        lookup_pc(1);                                   // Jump hit, counter still 01
        train_pc(2, 32'h0000_5000, bpu_pkg::br_cond, 1'b1);
        train_pc(2, 32'h0000_5000, bpu_pkg::br_cond, 1'b1);
        lookup_pc(2);
        repeat (4) train_pc(2, 32'h0000_5000, bpu_pkg::br_cond, 1'b0);
        lookup_pc(2);
        train_pc(2, 32'h0000_5000, bpu_pkg::br_cond, 1'b1);
        lookup_pc(2);
        train_pc(2, 32'h0000_5000, bpu_pkg::br_cond, 1'b1);
        lookup_pc(2);
        for (int i = 0; i < 12; i++) begin
            train_pc(i, 32'h0000_6000 + 32'(i) * 32'h10, bpu_pkg::br_type_e'(i[0]), 1'b1);
        end
        for (int i = 0; i < 12; i++) begin
            lookup_pc(i);                               // Early victims now miss
        end
        for (int n = 0; n < 3000; n++) begin
            r   = $random(seed);
            tgt = $random(seed);
            tgt[1:0] = 2'b00;
            run_cycle(r[0], int'(r[11:8]) % 12, r[1] | r[2], int'(r[15:12]) % 12, tgt,
                      bpu_pkg::br_type_e'(r[3] & r[4]), r[5]);
        end
        run_cycle(1'b0, 0, 1'b0, 0, 32'h0, bpu_pkg::br_cond, 1'b0);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
